// File: hw/ntt_pkg.sv
// sizes fixed for a 16-point forward NTT with 16-bit coefficients and two butterflies
package ntt_pkg;

    localparam int ring_depth   = 4;                       // log2 of the transform size
    localparam int ring_size    = 1 << ring_depth;
    localparam int pe_number    = 2;                       // butterflies working in parallel
    localparam int beats        = ring_size / (2 * pe_number);
    localparam int data_width   = 16;
    localparam int bfly_latency = 3;
    localparam int stage_gap    = bfly_latency + 1;        // idle cycles after a stage's last issue

    typedef logic [data_width-1:0]   coef_t;       // coefficient or modulus
    typedef logic [ring_depth-1:0]   coef_addr_t;
    typedef logic [ring_depth-2:0]   tw_idx_t;     // twiddle exponent, 0 .. N/2-1
    typedef logic [2:0]              stage_t;

    // lane k sits at bits data_width*k upward
    typedef logic [2*pe_number*data_width-1:0] lanes_t;

    typedef enum logic [2:0] {
        st_idle,
        st_load_tw,
        st_load_data,
        st_compute,
        st_output
    } run_state_t;

    // one issue slot for all butterflies; butterfly p works on pair i = 2*beat + p
    typedef struct packed {
        logic                       valid;
        logic [1:0]                 beat;
        tw_idx_t [pe_number-1:0]    tw_idx;
        logic                       src_bank;
    } bfly_issue_t;

endpackage

// File: hw/twiddle_store.sv
// holds w^0 .. w^(N/2-1) as loaded; no check that they are powers of one root
`timescale 1ns/1ps

module twiddle_store (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    tw_we,
    input  ntt_pkg::tw_idx_t                        tw_addr,
    input  ntt_pkg::coef_t                          tw_data,
    input  ntt_pkg::bfly_issue_t                    issue,
    output ntt_pkg::coef_t [ntt_pkg::pe_number-1:0] bfly_w
);

    ntt_pkg::coef_t tw_mem [ntt_pkg::ring_size/2];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int j = 0; j < ntt_pkg::ring_size / 2; j++) begin
                tw_mem[j] <= '0;
            end
        end else if (tw_we) begin
            tw_mem[tw_addr] <= tw_data;
        end
    end

    always_comb begin
        for (int p = 0; p < ntt_pkg::pe_number; p++) begin
            bfly_w[p] = tw_mem[issue.tw_idx[p]];   // one lookup per butterfly
        end
    end

endmodule

// File: hw/ct_butterfly.sv
// operands a and b must already be below q; q must stay stable while the pipe is busy
`timescale 1ns/1ps

module ct_butterfly (
    input  logic           clk,
    input  logic           reset,
    input  ntt_pkg::coef_t q,
    input  ntt_pkg::coef_t a,
    input  ntt_pkg::coef_t b,
    input  ntt_pkg::coef_t w,
    output ntt_pkg::coef_t sum,
    output ntt_pkg::coef_t diff
);

    logic [2*ntt_pkg::data_width-1:0] prod;
    ntt_pkg::coef_t                   a_d1;
    ntt_pkg::coef_t                   a_d2;
    ntt_pkg::coef_t                   p_red;
    logic [ntt_pkg::data_width:0]     add_full;

    assign add_full = a_d2 + p_red;   // one extra bit for the carry

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prod  <= '0;
            a_d1  <= '0;
            a_d2  <= '0;
            p_red <= '0;
            sum   <= '0;
            diff  <= '0;
        end else begin
            prod  <= w * b;                                // stage 1, plain multiply
            a_d1  <= a;
            p_red <= ntt_pkg::coef_t'(prod % q);           // stage 2, direct reduction
            a_d2  <= a_d1;
            sum   <= (add_full >= q) ? ntt_pkg::coef_t'(add_full - q)
                                     : ntt_pkg::coef_t'(add_full);
            diff  <= (a_d2 >= p_red) ? a_d2 - p_red
                                     : a_d2 + (q - p_red);  // wrap below zero
        end
    end

endmodule

// File: hw/coef_buffer.sv
// two register banks; load and output always use bank 0, reads are combinational
`timescale 1ns/1ps

module coef_buffer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load_we,
    input  ntt_pkg::coef_addr_t  load_addr,
    input  ntt_pkg::coef_t       load_data_in,
    input  ntt_pkg::bfly_issue_t issue,
    input  ntt_pkg::bfly_issue_t wb,
    input  ntt_pkg::lanes_t      sum,
    input  ntt_pkg::lanes_t      diff,
    input  logic [1:0]           out_beat,
    output ntt_pkg::lanes_t      bfly_a,
    output ntt_pkg::lanes_t      bfly_b,
    output ntt_pkg::lanes_t      out_lanes
);

    ntt_pkg::coef_t mem [2][ntt_pkg::ring_size];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int b = 0; b < 2; b++) begin
                for (int j = 0; j < ntt_pkg::ring_size; j++) begin
                    mem[b][j] <= '0;
                end
            end
        end else begin
            if (load_we) begin
                mem[0][load_addr] <= load_data_in;
            end
            // sum to i, difference to i + N/2 of the other bank
            if (wb.valid) begin
                for (int p = 0; p < ntt_pkg::pe_number; p++) begin
                    mem[!wb.src_bank][{1'b0, wb.beat, 1'(p)}] <=
                        sum[2*p*ntt_pkg::data_width +: ntt_pkg::data_width];
                    mem[!wb.src_bank][{1'b1, wb.beat, 1'(p)}] <=
                        diff[2*p*ntt_pkg::data_width +: ntt_pkg::data_width];
                end
            end
        end
    end

    always_comb begin
        bfly_a    = '0;
        bfly_b    = '0;
        out_lanes = '0;
        // pair (2i, 2i+1) with i = 2*beat + p
        for (int p = 0; p < ntt_pkg::pe_number; p++) begin
            bfly_a[2*p*ntt_pkg::data_width +: ntt_pkg::data_width] =
                mem[issue.src_bank][{issue.beat, 1'(p), 1'b0}];
            bfly_b[2*p*ntt_pkg::data_width +: ntt_pkg::data_width] =
                mem[issue.src_bank][{issue.beat, 1'(p), 1'b1}];
        end
        for (int k = 0; k < 2 * ntt_pkg::pe_number; k++) begin
            out_lanes[k*ntt_pkg::data_width +: ntt_pkg::data_width] = mem[0][{out_beat, 2'(k)}];
        end
    end

endmodule

// File: hw/ntt_addr_gen.sv
// constant-geometry schedule; a new compute_go while running restarts the count
`timescale 1ns/1ps

module ntt_addr_gen (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 compute_go,
    output ntt_pkg::bfly_issue_t issue,
    output ntt_pkg::bfly_issue_t wb,
    output logic                 finished
);

    logic                                                  running;
    ntt_pkg::stage_t                                       stage;
    logic [$clog2(ntt_pkg::beats + ntt_pkg::stage_gap)-1:0] phase;
    ntt_pkg::bfly_issue_t                                  pipe [ntt_pkg::bfly_latency];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            running  <= 1'b0;
            stage    <= '0;
            phase    <= '0;
            finished <= 1'b0;
        end else begin
            // last write-back of the last stage lands bfly_latency after its issue
            finished <= running && (stage == ntt_pkg::ring_depth - 1) &&
                        (phase == ntt_pkg::beats - 1 + ntt_pkg::bfly_latency);
            if (compute_go) begin
                running <= 1'b1;
                stage   <= '0;
                phase   <= '0;
            end else if (running) begin
                if (phase == ntt_pkg::beats + ntt_pkg::stage_gap - 1) begin
                    phase <= '0;
                    if (stage == ntt_pkg::ring_depth - 1) begin
                        running <= 1'b0;
                    end else begin
                        stage <= stage + 1'b1;
                    end
                end else begin
                    phase <= phase + 1'b1;
                end
            end
        end
    end

    always_comb begin
        ntt_pkg::tw_idx_t mask;
        ntt_pkg::tw_idx_t bf_i;

        mask           = '1;
        mask           = mask << (ntt_pkg::ring_depth - 1 - stage);   // keeps the top s bits
        issue          = '0;
        issue.valid    = running && (phase < ntt_pkg::beats);
        issue.beat     = phase[1:0];
        issue.src_bank = stage[0];   // banks swap every stage
        for (int p = 0; p < ntt_pkg::pe_number; p++) begin
            bf_i            = {phase[1:0], 1'(p)};
            issue.tw_idx[p] = bf_i & mask;
        end
    end

    // write-back follows the butterfly pipeline
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < ntt_pkg::bfly_latency; k++) begin
                pipe[k] <= '0;
            end
        end else begin
            pipe[0] <= issue;
            for (int k = 1; k < ntt_pkg::bfly_latency; k++) begin
                pipe[k] <= pipe[k-1];
            end
        end
    end

    assign wb = pipe[ntt_pkg::bfly_latency-1];

endmodule

// File: hw/ntt_control.sv
// pulses are taken only in idle, priority load_w > load_data > start; q holds its last loaded value
`timescale 1ns/1ps

module ntt_control (
    input  logic                clk,
    input  logic                reset,
    input  logic                load_w,
    input  logic                load_data,
    input  logic                start,
    input  ntt_pkg::coef_t      din,
    input  logic                finished,
    input  ntt_pkg::lanes_t     out_lanes,
    output logic                compute_go,
    output logic                tw_we,
    output ntt_pkg::tw_idx_t    tw_addr,
    output ntt_pkg::coef_t      tw_data,
    output ntt_pkg::coef_t      q,
    output logic                load_we,
    output ntt_pkg::coef_addr_t load_addr,
    output ntt_pkg::coef_t      load_data_in,
    output logic [1:0]          out_beat,
    output logic                done,
    output ntt_pkg::lanes_t     dout
);

    ntt_pkg::run_state_t        state;
    logic [ntt_pkg::ring_depth-1:0] sys_cntr;

    // twiddle load runs N/2 cycles of powers, then one cycle of q
    assign tw_we   = (state == ntt_pkg::st_load_tw) && (sys_cntr < ntt_pkg::ring_size / 2);
    assign tw_addr = ntt_pkg::tw_idx_t'(sys_cntr);
    assign tw_data = din;

    assign load_we      = (state == ntt_pkg::st_load_data);
    assign load_data_in = din;

    always_comb begin
        for (int b = 0; b < ntt_pkg::ring_depth; b++) begin
            load_addr[b] = sys_cntr[ntt_pkg::ring_depth-1-b];   // bit-reversed slot
        end
    end

    assign compute_go = (state == ntt_pkg::st_idle) && start && !load_w && !load_data;
    assign out_beat   = sys_cntr[1:0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= ntt_pkg::st_idle;
            sys_cntr <= '0;
            done     <= 1'b0;
            dout     <= '0;
        end else begin
            done <= 1'b0;
            dout <= '0;   // zero outside the output beats
            case (state)
                ntt_pkg::st_idle: begin
                    sys_cntr <= '0;
                    if (load_w) begin
                        state <= ntt_pkg::st_load_tw;
                    end else if (load_data) begin
                        state <= ntt_pkg::st_load_data;
                    end else if (start) begin
                        state <= ntt_pkg::st_compute;
                    end
                end
                ntt_pkg::st_load_tw: begin
                    if (sys_cntr == ntt_pkg::ring_size / 2) begin   // q cycle
                        state    <= ntt_pkg::st_idle;
                        sys_cntr <= '0;
                    end else begin
                        sys_cntr <= sys_cntr + 1'b1;
                    end
                end
                ntt_pkg::st_load_data: begin
                    if (sys_cntr == ntt_pkg::ring_size - 1) begin
                        state    <= ntt_pkg::st_idle;
                        sys_cntr <= '0;
                    end else begin
                        sys_cntr <= sys_cntr + 1'b1;
                    end
                end
                ntt_pkg::st_compute: begin
                    sys_cntr <= '0;
                    if (finished) begin
                        state <= ntt_pkg::st_output;
                        done  <= 1'b1;
                    end
                end
                ntt_pkg::st_output: begin
                    dout <= out_lanes;   // beat t shows one cycle after it is selected
                    if (sys_cntr == ntt_pkg::beats - 1) begin
                        state    <= ntt_pkg::st_idle;
                        sys_cntr <= '0;
                    end else begin
                        sys_cntr <= sys_cntr + 1'b1;
                    end
                end
                default: begin
                    state    <= ntt_pkg::st_idle;
                    sys_cntr <= '0;
                end
            endcase
        end
    end

    // modulus arrives on the cycle after the last twiddle power
    always_ff @(posedge clk) begin
        if ((state == ntt_pkg::st_load_tw) && (sys_cntr == ntt_pkg::ring_size / 2)) begin
            q <= din;
        end
    end

endmodule

// File: hw/ntt_core.sv
// forward NTT only; din timing follows the load_w / load_data pulses, output in natural order
`timescale 1ns/1ps

module ntt_core (
    input  logic            clk,
    input  logic            reset,
    input  logic            load_w,
    input  logic            load_data,
    input  logic            start,
    input  ntt_pkg::coef_t  din,
    output logic            done,
    output ntt_pkg::lanes_t dout
);

    logic                                   compute_go;
    logic                                   finished;
    logic                                   tw_we;
    ntt_pkg::tw_idx_t                       tw_addr;
    ntt_pkg::coef_t                         tw_data;
    ntt_pkg::coef_t                         q;
    logic                                   load_we;
    ntt_pkg::coef_addr_t                    load_addr;
    ntt_pkg::coef_t                         load_data_in;
    logic [1:0]                             out_beat;
    ntt_pkg::lanes_t                        out_lanes;
    ntt_pkg::bfly_issue_t                   issue;
    ntt_pkg::bfly_issue_t                   wb;
    ntt_pkg::lanes_t                        bfly_a;
    ntt_pkg::lanes_t                        bfly_b;
    ntt_pkg::lanes_t                        sum_lanes;
    ntt_pkg::lanes_t                        diff_lanes;
    ntt_pkg::coef_t [ntt_pkg::pe_number-1:0] bfly_w;

    ntt_control u_control (
        .clk          (clk),
        .reset        (reset),
        .load_w       (load_w),
        .load_data    (load_data),
        .start        (start),
        .din          (din),
        .finished     (finished),
        .out_lanes    (out_lanes),
        .compute_go   (compute_go),
        .tw_we        (tw_we),
        .tw_addr      (tw_addr),
        .tw_data      (tw_data),
        .q            (q),
        .load_we      (load_we),
        .load_addr    (load_addr),
        .load_data_in (load_data_in),
        .out_beat     (out_beat),
        .done         (done),
        .dout         (dout)
    );

    ntt_addr_gen u_addr_gen (
        .clk        (clk),
        .reset      (reset),
        .compute_go (compute_go),
        .issue      (issue),
        .wb         (wb),
        .finished   (finished)
    );

    coef_buffer u_coef_buffer (
        .clk          (clk),
        .reset        (reset),
        .load_we      (load_we),
        .load_addr    (load_addr),
        .load_data_in (load_data_in),
        .issue        (issue),
        .wb           (wb),
        .sum          (sum_lanes),
        .diff         (diff_lanes),
        .out_beat     (out_beat),
        .bfly_a       (bfly_a),
        .bfly_b       (bfly_b),
        .out_lanes    (out_lanes)
    );

    twiddle_store u_twiddle_store (
        .clk     (clk),
        .reset   (reset),
        .tw_we   (tw_we),
        .tw_addr (tw_addr),
        .tw_data (tw_data),
        .issue   (issue),
        .bfly_w  (bfly_w)
    );

    // butterfly p owns lanes 2p and 2p+1; only lane 2p carries data
    for (genvar p = 0; p < ntt_pkg::pe_number; p++) begin : g_bfly
        localparam int lo = 2 * p * ntt_pkg::data_width;
        localparam int hi = (2 * p + 1) * ntt_pkg::data_width;

        ntt_pkg::coef_t bfly_sum;
        ntt_pkg::coef_t bfly_diff;

        ct_butterfly u_bfly (
            .clk   (clk),
            .reset (reset),
            .q     (q),
            .a     (bfly_a[lo +: ntt_pkg::data_width]),
            .b     (bfly_b[lo +: ntt_pkg::data_width]),
            .w     (bfly_w[p]),
            .sum   (bfly_sum),
            .diff  (bfly_diff)
        );

        assign sum_lanes[lo +: ntt_pkg::data_width]  = bfly_sum;
        assign sum_lanes[hi +: ntt_pkg::data_width]  = '0;
        assign diff_lanes[lo +: ntt_pkg::data_width] = bfly_diff;
        assign diff_lanes[hi +: ntt_pkg::data_width] = '0;
    end

endmodule

// File: testbench/ntt_tb_model.svh
// direct-summation reference NTT; modulus below 2^16, w must satisfy w^8 = q-1 for a 16-point transform
`ifndef ntt_tb_model_svh
`define ntt_tb_model_svh

function automatic ntt_pkg::coef_t mul_mod(input ntt_pkg::coef_t x, input ntt_pkg::coef_t y,
                                           input ntt_pkg::coef_t m);
    logic [31:0] prod;
    prod = 32'(x) * 32'(y);   // full 32-bit product, no overflow
    return ntt_pkg::coef_t'(prod % 32'(m));
endfunction

function automatic ntt_pkg::coef_t pow_mod(input ntt_pkg::coef_t base, input int e,
                                           input ntt_pkg::coef_t m);
    ntt_pkg::coef_t r;
    r = ntt_pkg::coef_t'(1);
    for (int n = 0; n < e; n++) begin
        r = mul_mod(r, base, m);
    end
    return r;
endfunction

// brute-force search for a primitive 16th root of unity
function automatic ntt_pkg::coef_t find_root(input ntt_pkg::coef_t m);
    for (int c = 2; c < int'(m); c++) begin
        if (pow_mod(ntt_pkg::coef_t'(c), ntt_pkg::ring_size / 2, m) == m - 1) begin
            return ntt_pkg::coef_t'(c);
        end
    end
    return '0;
endfunction

// X[k] = sum over j of a[j] * w^(j*k) mod q
function automatic ntt_pkg::coef_t reference_coef(input ntt_pkg::coef_t a [ntt_pkg::ring_size],
                                                  input int k, input ntt_pkg::coef_t w,
                                                  input ntt_pkg::coef_t m);
    ntt_pkg::coef_t acc;
    ntt_pkg::coef_t term;
    acc = '0;
    for (int j = 0; j < ntt_pkg::ring_size; j++) begin
        term = mul_mod(a[j], pow_mod(w, (j * k) % ntt_pkg::ring_size, m), m);
        acc  = ntt_pkg::coef_t'((32'(acc) + 32'(term)) % 32'(m));
    end
    return acc;
endfunction

task automatic check_coef(input string what, input ntt_pkg::coef_t got,
                          input ntt_pkg::coef_t expected);
    if (got !== expected) begin
        $display("ERR %s: got 0x%h, expected 0x%h", what, got, expected);
        abort_run();
    end
endtask

task automatic check_done(input logic got, input logic expected);
    if (got !== expected) begin
        $display("ERR done: got 0x%h, expected 0x%h", got, expected);
        abort_run();
    end
endtask

`endif

// File: testbench/ntt_tb.sv
// directed tests only; each modulus used must have a 16th root of unity for the root search
`timescale 1ns/1ps

module ntt_tb;

    localparam int max_cycles = 2000;   // the five tests need about 400 cycles

    logic            clk;
    logic            reset;
    logic            load_w;
    logic            load_data;
    logic            start;
    ntt_pkg::coef_t  din;
    logic            done;
    ntt_pkg::lanes_t dout;

    ntt_pkg::coef_t  stim [ntt_pkg::ring_size];       // natural-order input vector
    ntt_pkg::coef_t  expect_x [ntt_pkg::ring_size];
    int              cycle_count = 0;

    ntt_core u_ntt_core (
        .clk       (clk),
        .reset     (reset),
        .load_w    (load_w),
        .load_data (load_data),
        .start     (start),
        .din       (din),
        .done      (done),
        .dout      (dout)
    );

    always #4 clk = ~clk;

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1);
    endtask

    `include "ntt_tb_model.svh"

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > max_cycles) begin
            $display("timeout: run went past %0d cycles", max_cycles);
            abort_run();
        end
    end

    task automatic step_cycle();
        @(posedge clk);
        #1;   // inputs change just after the edge
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic load_twiddles(input ntt_pkg::coef_t w, input ntt_pkg::coef_t m);
        load_w = 1'b1;
        step_cycle();
        load_w = 1'b0;
        for (int e = 0; e < ntt_pkg::ring_size / 2; e++) begin
            din = pow_mod(w, e, m);
            step_cycle();
        end
        din = m;   // modulus follows the last power
        step_cycle();
        din = '0;
    endtask

    task automatic load_vector();
        load_data = 1'b1;
        step_cycle();
        load_data = 1'b0;
        for (int j = 0; j < ntt_pkg::ring_size; j++) begin
            din = stim[j];
            step_cycle();
        end
        din = '0;
    endtask

    task automatic random_vector(input ntt_pkg::coef_t m);
        for (int j = 0; j < ntt_pkg::ring_size; j++) begin
            stim[j] = ntt_pkg::coef_t'($urandom % m);
        end
    endtask

    task automatic fill_expected(input ntt_pkg::coef_t w, input ntt_pkg::coef_t m);
        for (int k = 0; k < ntt_pkg::ring_size; k++) begin
            expect_x[k] = reference_coef(stim, k, w, m);
        end
    endtask

    task automatic check_dout_zero(input string tag);
        for (int k = 0; k < 2 * ntt_pkg::pe_number; k++) begin
            check_coef($sformatf("%s dout lane %0d", tag, k),
                       dout[k*ntt_pkg::data_width +: ntt_pkg::data_width], '0);
        end
    endtask

    // pulse start, wait for done, then compare the four output beats
    task automatic run_and_check(input string tag);
        int waited;
        waited = 0;
        start  = 1'b1;
        step_cycle();
        start  = 1'b0;
        @(negedge clk);
        while (done !== 1'b1 && waited < 64) begin
            @(negedge clk);
            waited++;
        end
        if (done !== 1'b1) begin
            $display("%s: done did not arrive within 64 cycles of start", tag);
            abort_run();
        end
        check_dout_zero({tag, " at done"});   // beats come only after done
        for (int t = 0; t < ntt_pkg::beats; t++) begin
            @(negedge clk);
            check_done(done, 1'b0);
            for (int k = 0; k < 2 * ntt_pkg::pe_number; k++) begin
                check_coef($sformatf("%s dout X[%0d]", tag, 4 * t + k),
                           dout[k*ntt_pkg::data_width +: ntt_pkg::data_width],
                           expect_x[4*t + k]);
            end
        end
        @(negedge clk);
        check_done(done, 1'b0);
        check_dout_zero({tag, " after beats"});
        step_cycle();
    endtask

    task automatic test_impulse();
        for (int j = 0; j < ntt_pkg::ring_size; j++) begin
            stim[j]     = (j == 0) ? 16'd1 : 16'd0;
            expect_x[j] = 16'd1;   // flat spectrum
        end
        load_twiddles(16'd3, 16'd17);
        load_vector();
        run_and_check("impulse");
    endtask

    task automatic test_random_vector();
        ntt_pkg::coef_t w;
        w = find_root(16'd7681);
        load_twiddles(w, 16'd7681);
        random_vector(16'd7681);
        load_vector();
        fill_expected(w, 16'd7681);
        run_and_check("random");
    endtask

    // twiddles and q stay from the previous test
    task automatic test_second_transform();
        ntt_pkg::coef_t w;
        w = find_root(16'd7681);
        random_vector(16'd7681);
        load_vector();
        fill_expected(w, 16'd7681);
        run_and_check("second");
    endtask

    task automatic test_reload();
        ntt_pkg::coef_t w;
        w = find_root(16'd97);
        load_twiddles(w, 16'd97);
        random_vector(16'd97);
        load_vector();
        fill_expected(w, 16'd97);
        run_and_check("reload");
    endtask

    task automatic test_reset_mid_compute();
        ntt_pkg::coef_t w;
        w = find_root(16'd97);
        random_vector(16'd97);
        load_vector();
        start = 1'b1;
        step_cycle();
        start = 1'b0;
        repeat (12) step_cycle();   // well inside the second stage
        apply_reset();
        repeat (48) begin
            @(negedge clk);
            check_done(done, 1'b0);
            check_dout_zero("reset");
        end
        step_cycle();
        load_twiddles(w, 16'd97);   // reset cleared the twiddle registers
        load_vector();
        fill_expected(w, 16'd97);
        run_and_check("after reset");
    endtask

    initial begin
        void'($urandom(32'h1609_8dde));
        clk       = 1'b0;
        reset     = 1'b1;
        load_w    = 1'b0;
        load_data = 1'b0;
        start     = 1'b0;
        din       = '0;
        apply_reset();
        test_impulse();
        test_random_vector();
        test_second_transform();
        test_reload();
        test_reset_mid_compute();
        $display("All tests passed");
        $finish;
    end

endmodule

// File: ntt_core.f
+incdir+testbench
hw/ntt_pkg.sv
hw/twiddle_store.sv
hw/ct_butterfly.sv
hw/coef_buffer.sv
hw/ntt_addr_gen.sv
hw/ntt_control.sv
hw/ntt_core.sv
testbench/ntt_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the NTT testbench with Verilator; exit status follows the test result
cd "$(dirname "$0")" || exit 1
log=sim.log
verilator --binary --timing -Wno-fatal --top-module ntt_tb -f ntt_core.f -o ntt_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/ntt_sim > "$log" 2>&1
cat "$log"
grep -q "Some tests failed" "$log" && { echo "simulation failed"; exit 1; }
grep -q "All tests passed" "$log" || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
